// File: hw/policer_settings.svh
// Policer sizing macros
// Port count, beat width and bucket fixed-point split
`ifndef POLICER_SETTINGS_SVH
`define POLICER_SETTINGS_SVH

// Ingress ports, one bucket each
`define POLICER_NUM_PORTS 4

// Beat data width in bits
`define POLICER_DATA_W 32

// Packet byte-length field
`define POLICER_LEN_W 12

// Bucket fixed point, whole bytes then fraction
`define POLICER_WHOLE_W 16
`define POLICER_FRAC_W 16

// Port index width, log2 of the port count
`define POLICER_PORT_W 2

`endif

// File: hw/policer_pkg.sv
// Policer shared types
// Port and length fields, table select and the bucket fixed-point word
`default_nettype none

`include "policer_settings.svh"

package policer_pkg;

    ////////////////////////////////
    // Beat sideband fields
    ////////////////////////////////

    typedef logic [`POLICER_PORT_W-1:0] port_id_t;
    typedef logic [`POLICER_LEN_W-1:0] byte_len_t;

    // Config address bits 7:6
    typedef enum logic [1:0] {
        TBL_RATE        = 2'd0,
        TBL_THRESH      = 2'd1,
        TBL_ENABLE_RSVD = 2'd2
    } table_sel_t;

    ////////////////////////////////
    // Bucket fixed point
    ////////////////////////////////

    typedef struct packed {
        logic [`POLICER_WHOLE_W-1:0] whole;
        logic [`POLICER_FRAC_W-1:0]  fraction;
    } bucket_fixed_t;

    // Same word, arithmetic view or whole/fraction view
    typedef union packed {
        logic [`POLICER_WHOLE_W+`POLICER_FRAC_W-1:0] raw;
        bucket_fixed_t                               fixed;
    } bucket_t;

endpackage

`default_nettype wire

// File: hw/policer_config.sv
// Policer configuration tables
// Per-port drain rate and threshold, strobed write and read-back
`default_nettype none

`include "policer_settings.svh"

module policer_config (
    input  logic                                                 packet_in,
    input  logic                                                 rst,
    input  logic                                                 cfg_wr,
    input  logic                                                 cfg_rd,
    input  logic [7:0]                                           cfg_addr,
    input  logic [31:0]                                          cfg_wdata,
    output logic                                                 cfg_done,
    output logic                                                 cfg_err,
    output logic                                                 cfg_rvalid,
    output logic [31:0]                                          cfg_rdata,
    output logic [`POLICER_NUM_PORTS*$bits(policer_pkg::bucket_t)-1:0] rate_table,
    output logic [`POLICER_NUM_PORTS*`POLICER_WHOLE_W-1:0]       thresh_table
);

    localparam int RATE_W   = $bits(policer_pkg::bucket_t);
    localparam int THRESH_W = `POLICER_WHOLE_W;

    policer_pkg::table_sel_t sel;
    policer_pkg::port_id_t   idx;
    logic                    port_ok;
    logic                    addr_ok;
    logic [31:0]             rd_word;

    ////////////////////////////////
    // Address decode
    ////////////////////////////////

    assign sel     = policer_pkg::table_sel_t'(cfg_addr[7:6]);
    assign idx     = cfg_addr[`POLICER_PORT_W-1:0];
    assign port_ok = cfg_addr[5:0] < `POLICER_NUM_PORTS;
    // Reserved select and the unnamed code both fail
    assign addr_ok = port_ok &&
                     (sel == policer_pkg::TBL_RATE || sel == policer_pkg::TBL_THRESH);

    // Read mux, threshold zero-extended
    always_comb begin
        case (sel)
            policer_pkg::TBL_RATE:   rd_word = rate_table[idx*RATE_W +: RATE_W];
            policer_pkg::TBL_THRESH: rd_word = 32'(thresh_table[idx*THRESH_W +: THRESH_W]);
            default:                 rd_word = '0;
        endcase
    end

    ////////////////////////////////
    // Tables and responses
    ////////////////////////////////

    always_ff @(posedge packet_in) begin
        if (rst) begin
            cfg_done     <= 1'b0;
            cfg_err      <= 1'b0;
            cfg_rvalid   <= 1'b0;
            rate_table   <= '0;
            thresh_table <= '0;
        end else begin
            // One-cycle response pulses
            cfg_done   <= cfg_wr;
            cfg_rvalid <= cfg_rd;
            cfg_err    <= (cfg_wr || cfg_rd) && !addr_ok;
            // Bad writes leave tables alone
            if (cfg_wr && addr_ok) begin
                case (sel)
                    policer_pkg::TBL_RATE:
                        rate_table[idx*RATE_W +: RATE_W] <= cfg_wdata;
                    policer_pkg::TBL_THRESH:
                        thresh_table[idx*THRESH_W +: THRESH_W] <= cfg_wdata[THRESH_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data, zero on a bad address
    always_ff @(posedge packet_in) begin
        if (cfg_rd) begin
            cfg_rdata <= addr_ok ? rd_word : '0;
        end
    end

    a_no_wr_rd_overlap: assert property (@(posedge packet_in) disable iff (rst)
        !(cfg_wr && cfg_rd));

endmodule

`default_nettype wire

// File: hw/policer_head_detect.sv
// Policer stage one
// Registers beats, flags the packet head and holds its port and length
`default_nettype none

`include "policer_settings.svh"

module policer_head_detect (
    input  logic                       packet_in,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic [`POLICER_DATA_W-1:0] in_data,
    input  logic                       in_last,
    input  policer_pkg::port_id_t      in_port,
    input  policer_pkg::byte_len_t     in_len,
    output logic                       s1_valid,
    output logic                       s1_head,
    output logic [`POLICER_DATA_W-1:0] s1_data,
    output logic                       s1_last,
    output policer_pkg::port_id_t      s1_port,
    output policer_pkg::byte_len_t     s1_len
);

    // Next valid beat starts a packet
    logic expect_head;

    always_ff @(posedge packet_in) begin
        if (rst) begin
            expect_head <= 1'b1;
            s1_valid    <= 1'b0;
            s1_head     <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s1_head  <= in_valid && expect_head;
            if (in_valid) begin
                expect_head <= in_last;
            end
        end
    end

    ////////////////////////////////
    // Beat payload
    ////////////////////////////////

    always_ff @(posedge packet_in) begin
        s1_data <= in_data;
        s1_last <= in_last;
        // Sampled at head only, held for the body beats
        if (in_valid && expect_head) begin
            s1_port <= in_port;
            s1_len  <= in_len;
        end
    end

    // Zero length would never fill a bucket
    a_head_len_nonzero: assert property (@(posedge packet_in) disable iff (rst)
        in_valid && expect_head |-> in_len != '0);

endmodule

`default_nettype wire

// File: hw/policer_bucket.sv
// Policer stage two
// Per-port leaky buckets, drop decision at each packet head
`default_nettype none

`include "policer_settings.svh"

module policer_bucket (
    input  logic                                                 packet_in,
    input  logic                                                 rst,
    input  logic [`POLICER_NUM_PORTS-1:0]                        enable,
    input  logic [`POLICER_NUM_PORTS*$bits(policer_pkg::bucket_t)-1:0] rate_table,
    input  logic [`POLICER_NUM_PORTS*`POLICER_WHOLE_W-1:0]       thresh_table,
    input  logic                                                 s1_valid,
    input  logic                                                 s1_head,
    input  logic [`POLICER_DATA_W-1:0]                           s1_data,
    input  logic                                                 s1_last,
    input  policer_pkg::port_id_t                                s1_port,
    input  policer_pkg::byte_len_t                               s1_len,
    output logic                                                 s2_valid,
    output logic                                                 s2_head,
    output logic                                                 s2_drop,
    output logic [`POLICER_DATA_W-1:0]                           s2_data,
    output logic                                                 s2_last,
    output policer_pkg::port_id_t                                s2_port,
    output policer_pkg::byte_len_t                               s2_len
);

    localparam int N        = `POLICER_NUM_PORTS;
    localparam int BUCKET_W = $bits(policer_pkg::bucket_t);
    localparam int THRESH_W = `POLICER_WHOLE_W;

    policer_pkg::bucket_t  bucket      [N];
    policer_pkg::bucket_t  next_bucket [N];
    policer_pkg::bucket_t  rate        [N];
    logic [THRESH_W-1:0]   thresh      [N];
    // One extra bit for carry out of the sums
    logic [THRESH_W:0]     level       [N];
    logic [BUCKET_W:0]     base        [N];
    logic [BUCKET_W:0]     fill_amt;
    logic [N-1:0]          head_hit;
    logic [N-1:0]          over;
    logic [N-1:0]          drop_vec;

    // Packet length moved into the whole part
    assign fill_amt = (BUCKET_W+1)'(s1_len) << `POLICER_FRAC_W;

    ////////////////////////////////
    // Bucket next state
    ////////////////////////////////

    always_comb begin
        for (int p = 0; p < N; p++) begin
            rate[p]   = rate_table[p*BUCKET_W +: BUCKET_W];
            thresh[p] = thresh_table[p*THRESH_W +: THRESH_W];

            // Threshold test on whole bytes only
            level[p]    = {1'b0, bucket[p].fixed.whole} + (THRESH_W+1)'(s1_len);
            over[p]     = level[p] > {1'b0, thresh[p]};
            head_hit[p] = s1_valid && s1_head && (s1_port == policer_pkg::port_id_t'(p));
            drop_vec[p] = head_hit[p] && enable[p] && over[p];

            // Accepted head adds its length before the drain
            if (head_hit[p] && !over[p]) begin
                base[p] = {1'b0, bucket[p].raw} + fill_amt;
            end else begin
                base[p] = {1'b0, bucket[p].raw};
            end

            // Drain, saturating at zero
            if (!enable[p]) begin
                next_bucket[p].raw = '0;
            end else if (base[p] > {1'b0, rate[p].raw}) begin
                next_bucket[p].raw = BUCKET_W'(base[p] - {1'b0, rate[p].raw});
            end else begin
                next_bucket[p].raw = '0;
            end
        end
    end

    always_ff @(posedge packet_in) begin
        if (rst) begin
            for (int p = 0; p < N; p++) begin
                bucket[p] <= '0;
            end
        end else begin
            for (int p = 0; p < N; p++) begin
                bucket[p] <= next_bucket[p];
            end
        end
    end

    ////////////////////////////////
    // Beat and decision register
    ////////////////////////////////

    always_ff @(posedge packet_in) begin
        if (rst) begin
            s2_valid <= 1'b0;
            s2_head  <= 1'b0;
            s2_drop  <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_head  <= s1_valid && s1_head;
            // At most one port sees the head
            s2_drop  <= |drop_vec;
        end
    end

    always_ff @(posedge packet_in) begin
        s2_data <= s1_data;
        s2_last <= s1_last;
        s2_port <= s1_port;
        s2_len  <= s1_len;
    end

    a_drop_only_at_head: assert property (@(posedge packet_in) disable iff (rst)
        s2_drop |-> s2_head);

    for (genvar g = 0; g < N; g++) begin : g_dis_chk
        a_disabled_empty: assert property (@(posedge packet_in) disable iff (rst)
            !enable[g] |=> bucket[g].raw == '0);
    end

endmodule

`default_nettype wire

// File: hw/policer_marker.sv
// Policer stage three
// Spreads the head's drop mark over the whole packet
`default_nettype none

`include "policer_settings.svh"

module policer_marker (
    input  logic                       packet_in,
    input  logic                       rst,
    input  logic                       s2_valid,
    input  logic                       s2_head,
    input  logic                       s2_drop,
    input  logic [`POLICER_DATA_W-1:0] s2_data,
    input  logic                       s2_last,
    input  policer_pkg::port_id_t      s2_port,
    input  policer_pkg::byte_len_t     s2_len,
    output logic                       out_valid,
    output logic [`POLICER_DATA_W-1:0] out_data,
    output logic                       out_last,
    output policer_pkg::port_id_t      out_port,
    output policer_pkg::byte_len_t     out_len,
    output logic                       out_drop
);

    // Decision of the packet in flight
    logic drop_hold;

    always_ff @(posedge packet_in) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_drop  <= 1'b0;
            drop_hold <= 1'b0;
        end else begin
            out_valid <= s2_valid;
            if (s2_valid && s2_head) begin
                drop_hold <= s2_drop;
            end
            // Head uses its fresh mark, body beats the held one
            if (s2_valid) begin
                out_drop <= s2_head ? s2_drop : drop_hold;
            end
        end
    end

    ////////////////////////////////
    // Output beat
    ////////////////////////////////

    always_ff @(posedge packet_in) begin
        out_data <= s2_data;
        out_last <= s2_last;
        out_port <= s2_port;
        out_len  <= s2_len;
    end

    a_drop_steady_in_packet: assert property (@(posedge packet_in) disable iff (rst)
        out_valid && !out_last |=> $stable(out_drop));

endmodule

`default_nettype wire

// File: hw/policer_top.sv
// Ingress policer top
// Head detect, bucket and marker stages with the config tables
`default_nettype none

`include "policer_settings.svh"

module policer_top (
    input  logic                          packet_in,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [`POLICER_DATA_W-1:0]    in_data,
    input  logic                          in_last,
    input  policer_pkg::port_id_t         in_port,
    input  policer_pkg::byte_len_t        in_len,
    input  logic [`POLICER_NUM_PORTS-1:0] enable,
    input  logic                          cfg_wr,
    input  logic                          cfg_rd,
    input  logic [7:0]                    cfg_addr,
    input  logic [31:0]                   cfg_wdata,
    output logic                          out_valid,
    output logic [`POLICER_DATA_W-1:0]    out_data,
    output logic                          out_last,
    output policer_pkg::port_id_t         out_port,
    output policer_pkg::byte_len_t        out_len,
    output logic                          out_drop,
    output logic                          cfg_done,
    output logic                          cfg_err,
    output logic                          cfg_rvalid,
    output logic [31:0]                   cfg_rdata
);

    ////////////////////////////////
    // Inter-stage wires
    ////////////////////////////////

    logic [`POLICER_NUM_PORTS*$bits(policer_pkg::bucket_t)-1:0] rate_table;
    logic [`POLICER_NUM_PORTS*`POLICER_WHOLE_W-1:0]             thresh_table;

    logic                       s1_valid;
    logic                       s1_head;
    logic [`POLICER_DATA_W-1:0] s1_data;
    logic                       s1_last;
    policer_pkg::port_id_t      s1_port;
    policer_pkg::byte_len_t     s1_len;

    logic                       s2_valid;
    logic                       s2_head;
    logic                       s2_drop;
    logic [`POLICER_DATA_W-1:0] s2_data;
    logic                       s2_last;
    policer_pkg::port_id_t      s2_port;
    policer_pkg::byte_len_t     s2_len;

    policer_config u_config (
        .packet_in    (packet_in),
        .rst          (rst),
        .cfg_wr       (cfg_wr),
        .cfg_rd       (cfg_rd),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_done     (cfg_done),
        .cfg_err      (cfg_err),
        .cfg_rvalid   (cfg_rvalid),
        .cfg_rdata    (cfg_rdata),
        .rate_table   (rate_table),
        .thresh_table (thresh_table)
    );

    // Stage one
    policer_head_detect u_head_detect (
        .packet_in (packet_in),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_port   (in_port),
        .in_len    (in_len),
        .s1_valid  (s1_valid),
        .s1_head   (s1_head),
        .s1_data   (s1_data),
        .s1_last   (s1_last),
        .s1_port   (s1_port),
        .s1_len    (s1_len)
    );

    // Stage two
    policer_bucket u_bucket (
        .packet_in    (packet_in),
        .rst          (rst),
        .enable       (enable),
        .rate_table   (rate_table),
        .thresh_table (thresh_table),
        .s1_valid     (s1_valid),
        .s1_head      (s1_head),
        .s1_data      (s1_data),
        .s1_last      (s1_last),
        .s1_port      (s1_port),
        .s1_len       (s1_len),
        .s2_valid     (s2_valid),
        .s2_head      (s2_head),
        .s2_drop      (s2_drop),
        .s2_data      (s2_data),
        .s2_last      (s2_last),
        .s2_port      (s2_port),
        .s2_len       (s2_len)
    );

    // Stage three
    policer_marker u_marker (
        .packet_in (packet_in),
        .rst       (rst),
        .s2_valid  (s2_valid),
        .s2_head   (s2_head),
        .s2_drop   (s2_drop),
        .s2_data   (s2_data),
        .s2_last   (s2_last),
        .s2_port   (s2_port),
        .s2_len    (s2_len),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_port  (out_port),
        .out_len   (out_len),
        .out_drop  (out_drop)
    );

endmodule

`default_nettype wire

// File: verification/policer_tb.sv
// Policer testbench
// Directed config, pass-through, fill, port and drain tests against a bucket model
`default_nettype none

`include "policer_settings.svh"

module policer_tb;

    localparam int N       = `POLICER_NUM_PORTS;
    localparam int LATENCY = 3;

    logic                       packet_in;
    logic                       rst;
    logic                       in_valid;
    logic [`POLICER_DATA_W-1:0] in_data;
    logic                       in_last;
    policer_pkg::port_id_t      in_port;
    policer_pkg::byte_len_t     in_len;
    logic [N-1:0]               enable;
    logic                       cfg_wr;
    logic                       cfg_rd;
    logic [7:0]                 cfg_addr;
    logic [31:0]                cfg_wdata;
    logic                       out_valid;
    logic [`POLICER_DATA_W-1:0] out_data;
    logic                       out_last;
    policer_pkg::port_id_t      out_port;
    policer_pkg::byte_len_t     out_len;
    logic                       out_drop;
    logic                       cfg_done;
    logic                       cfg_err;
    logic                       cfg_rvalid;
    logic [31:0]                cfg_rdata;

    int    cycle = 0;
    string current_test = "reset";

    // Head tracking on the driven side
    logic                   next_is_head;
    policer_pkg::port_id_t  pkt_port;
    policer_pkg::byte_len_t pkt_len;
    logic                   pkt_drop;

    // Beats in flight, oldest first
    logic [31:0] q_data [$];
    logic        q_last [$];
    logic [31:0] q_port [$];
    logic [31:0] q_len  [$];
    logic        q_drop [$];
    int          q_cycle [$];

    // Reference buckets and table mirror
    logic [31:0] model_bucket [N];
    logic [31:0] model_rate   [N];
    logic [15:0] model_thresh [N];

    policer_top uut (
        .packet_in  (packet_in),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_last    (in_last),
        .in_port    (in_port),
        .in_len     (in_len),
        .enable     (enable),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_port   (out_port),
        .out_len    (out_len),
        .out_drop   (out_drop),
        .cfg_done   (cfg_done),
        .cfg_err    (cfg_err),
        .cfg_rvalid (cfg_rvalid),
        .cfg_rdata  (cfg_rdata)
    );

    initial begin
        packet_in = 1'b0;
        forever #20 packet_in = ~packet_in;
    end

    always @(posedge packet_in) cycle <= cycle + 1;

    ////////////////////////////////
    // Checking
    ////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: %s expected 0x%0h, actual 0x%0h",
                                current_test, what, expected, actual));
        end
    endtask

    // Output side, sampled mid-cycle
    always @(negedge packet_in) begin
        if (!rst) begin
            if (out_valid) begin
                if (q_data.size() == 0) begin
                    abort_run($sformatf("%s: output beat appeared with nothing sent",
                                        current_test));
                end else begin
                    check_value("latency", q_cycle[0] + LATENCY, cycle);
                    check_value("out_data", q_data[0], out_data);
                    check_value("out_last", q_last[0], out_last);
                    check_value("out_port", q_port[0], out_port);
                    check_value("out_len", q_len[0], out_len);
                    check_value("out_drop", q_drop[0], out_drop);
                    void'(q_data.pop_front());
                    void'(q_last.pop_front());
                    void'(q_port.pop_front());
                    void'(q_len.pop_front());
                    void'(q_drop.pop_front());
                    void'(q_cycle.pop_front());
                end
            end else if (q_data.size() != 0 && cycle >= q_cycle[0] + LATENCY) begin
                abort_run($sformatf("%s: a sent beat never reached the output",
                                    current_test));
            end
        end
    end

    ////////////////////////////////
    // Reference bucket model
    ////////////////////////////////

    task automatic model_step(input logic head, input policer_pkg::port_id_t port,
                              input policer_pkg::byte_len_t len, output logic drop);
        logic [32:0] amount;
        drop = 1'b0;
        for (int p = 0; p < N; p++) begin
            if (!enable[p]) begin
                model_bucket[p] = '0;
            end else begin
                amount = {1'b0, model_bucket[p]};
                if (head && port == p) begin
                    // Whole bytes plus new length against threshold
                    if (int'(model_bucket[p] >> `POLICER_FRAC_W) + int'(len)
                            > int'(model_thresh[p])) begin
                        drop = 1'b1;
                    end else begin
                        amount = amount + (33'(len) << `POLICER_FRAC_W);
                    end
                end
                if (amount > {1'b0, model_rate[p]}) begin
                    model_bucket[p] = 32'(amount - {1'b0, model_rate[p]});
                end else begin
                    model_bucket[p] = '0;
                end
            end
        end
    endtask

    ////////////////////////////////
    // Drive helpers
    ////////////////////////////////

    // Commit this cycle's inputs, then move to the next falling edge
    task automatic advance();
        logic head;
        logic drop;
        head = in_valid && next_is_head;
        model_step(head, in_port, in_len, drop);
        if (in_valid) begin
            if (head) begin
                pkt_port = in_port;
                pkt_len  = in_len;
                pkt_drop = drop;
            end
            q_data.push_back(in_data);
            q_last.push_back(in_last);
            q_port.push_back(32'(pkt_port));
            q_len.push_back(32'(pkt_len));
            q_drop.push_back(pkt_drop);
            q_cycle.push_back(cycle);
            next_is_head = in_last;
        end
        @(negedge packet_in);
        in_valid = 1'b0;
        in_last  = 1'b0;
        cfg_wr   = 1'b0;
        cfg_rd   = 1'b0;
    endtask

    task automatic send_packet(input int port, input int len, input int beats,
                               output logic drop);
        for (int b = 0; b < beats; b++) begin
            in_valid = 1'b1;
            in_data  = $urandom;
            in_last  = (b == beats - 1);
            if (b == 0) begin
                in_port = port;
                in_len  = len;
            end else begin
                // Junk sideband on body beats
                in_port = $urandom;
                in_len  = $urandom;
            end
            advance();
        end
        drop = pkt_drop;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (q_data.size() != 0) begin
            n++;
            if (n > 20) begin
                abort_run($sformatf("%s: pipeline did not empty in time", current_test));
            end
            advance();
        end
    endtask

    task automatic clear_buckets();
        logic [N-1:0] keep;
        keep   = enable;
        enable = '0;
        advance();
        advance();
        enable = keep;
        advance();
    endtask

    task automatic cfg_write(input logic [1:0] sel, input int port, input logic [31:0] data,
                             input logic exp_err);
        int n;
        cfg_wr    = 1'b1;
        cfg_addr  = {sel, 6'(port)};
        cfg_wdata = data;
        advance();
        n = 0;
        while (!cfg_done) begin
            n++;
            if (n > 8) begin
                abort_run($sformatf("%s: cfg_done never followed a write", current_test));
            end
            advance();
        end
        check_value("cfg_done delay", 0, n);
        check_value("write error flag", exp_err, cfg_err);
        if (!exp_err && sel == policer_pkg::TBL_RATE) model_rate[port] = data;
        if (!exp_err && sel == policer_pkg::TBL_THRESH) model_thresh[port] = data[15:0];
    endtask

    task automatic cfg_read(input logic [1:0] sel, input int port, input logic [31:0] exp_data,
                            input logic exp_err);
        int n;
        cfg_rd   = 1'b1;
        cfg_addr = {sel, 6'(port)};
        advance();
        n = 0;
        while (!cfg_rvalid) begin
            n++;
            if (n > 8) begin
                abort_run($sformatf("%s: cfg_rvalid never followed a read", current_test));
            end
            advance();
        end
        check_value("cfg_rvalid delay", 0, n);
        check_value("read data", exp_data, cfg_rdata);
        check_value("read error flag", exp_err, cfg_err);
    endtask

    ////////////////////////////////
    // Directed tests
    ////////////////////////////////

    task automatic test_config();
        current_test = "config";
        cfg_write(policer_pkg::TBL_RATE, 0, 32'h0012_3456, 1'b0);
        cfg_write(policer_pkg::TBL_THRESH, 0, 32'h1234_BEEF, 1'b0);
        cfg_write(policer_pkg::TBL_RATE, 1, 32'h00AB_CDEF, 1'b0);
        cfg_read(policer_pkg::TBL_RATE, 0, 32'h0012_3456, 1'b0);
        // Only the low 16 bits of a threshold are kept
        cfg_read(policer_pkg::TBL_THRESH, 0, 32'h0000_BEEF, 1'b0);
        cfg_write(policer_pkg::TBL_ENABLE_RSVD, 0, 32'hDEAD_BEEF, 1'b1);
        cfg_read(policer_pkg::TBL_RATE, 0, 32'h0012_3456, 1'b0);
        cfg_read(policer_pkg::TBL_THRESH, 0, 32'h0000_BEEF, 1'b0);
        // Port 5 aliases port 1 in the low bits
        cfg_write(policer_pkg::TBL_RATE, 5, 32'h5555_5555, 1'b1);
        cfg_read(policer_pkg::TBL_RATE, 1, 32'h00AB_CDEF, 1'b0);
        cfg_read(policer_pkg::TBL_RATE, 5, 32'h0000_0000, 1'b1);
    endtask

    task automatic test_pass_through();
        logic drop;
        current_test = "pass_through";
        // Rate far above any fill keeps the bucket empty
        cfg_write(policer_pkg::TBL_RATE, 0, 32'hFFFF_FFFF, 1'b0);
        cfg_write(policer_pkg::TBL_THRESH, 0, 32'h0000_FFFF, 1'b0);
        for (int k = 0; k < 8; k++) begin
            send_packet(0, 1 + ($urandom % 4095), 1 + ($urandom % 5), drop);
            check_value("head drop", 0, drop);
        end
        wait_drain();
    endtask

    task automatic test_fill();
        logic drop;
        int   len;
        int   marked;
        int   accepted_bytes;
        current_test = "fill";
        cfg_write(policer_pkg::TBL_RATE, 0, 32'h0, 1'b0);
        cfg_write(policer_pkg::TBL_THRESH, 0, 32'd1000, 1'b0);
        clear_buckets();
        marked = 0;
        accepted_bytes = 0;
        for (int k = 0; k < 14; k++) begin
            len = 40 + ($urandom % 260);
            send_packet(0, len, 1 + ($urandom % 3), drop);
            // Zero rate, bucket holds exactly the accepted bytes
            check_value("mark against accepted total", accepted_bytes + len > 1000, drop);
            if (drop) begin
                marked++;
            end else begin
                accepted_bytes += len;
            end
        end
        check_value("some packets marked", 1, marked > 0);
        // Top-up lands exactly on the threshold
        if (accepted_bytes < 1000) begin
            send_packet(0, 1000 - accepted_bytes, 2, drop);
            check_value("fill to threshold", 0, drop);
        end
        send_packet(0, 1, 1, drop);
        check_value("one byte over threshold", 1, drop);
        wait_drain();
    endtask

    task automatic test_ports();
        logic drop;
        current_test = "ports";
        for (int p = 1; p <= 2; p++) begin
            cfg_write(policer_pkg::TBL_RATE, p, 32'h0, 1'b0);
            cfg_write(policer_pkg::TBL_THRESH, p, 32'd200, 1'b0);
        end
        clear_buckets();
        send_packet(1, 150, 2, drop);
        check_value("port 1 first", 0, drop);
        send_packet(1, 150, 1, drop);
        check_value("port 1 full", 1, drop);
        send_packet(2, 150, 2, drop);
        check_value("port 2 independent", 0, drop);
        wait_drain();
        // Disabled port never marks
        enable[1] = 1'b0;
        advance();
        advance();
        send_packet(1, 300, 2, drop);
        check_value("disabled port 1", 0, drop);
        send_packet(1, 300, 1, drop);
        check_value("disabled port 1 again", 0, drop);
        wait_drain();
        enable[1] = 1'b1;
        advance();
        send_packet(1, 150, 1, drop);
        check_value("port 1 emptied", 0, drop);
        send_packet(2, 100, 1, drop);
        check_value("port 2 kept its fill", 1, drop);
        wait_drain();
    endtask

    task automatic test_drain();
        logic drop;
        current_test = "drain";
        // 64 bytes per clock in the whole part
        cfg_write(policer_pkg::TBL_RATE, 3, 32'h0040_0000, 1'b0);
        cfg_write(policer_pkg::TBL_THRESH, 3, 32'd100, 1'b0);
        clear_buckets();
        send_packet(3, 100, 1, drop);
        check_value("first packet", 0, drop);
        send_packet(3, 100, 1, drop);
        check_value("back-to-back packet", 1, drop);
        repeat (4) advance();
        send_packet(3, 100, 1, drop);
        check_value("after idle gap", 0, drop);
        wait_drain();
    endtask

    ////////////////////////////////
    // Main sequence
    ////////////////////////////////

    initial begin
        int unsigned seed;
        seed = 57068;
        void'($urandom(seed));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        in_last      = 1'b0;
        in_port      = '0;
        in_len       = '0;
        enable       = '0;
        cfg_wr       = 1'b0;
        cfg_rd       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        next_is_head = 1'b1;
        pkt_port     = '0;
        pkt_len      = '0;
        pkt_drop     = 1'b0;
        for (int p = 0; p < N; p++) begin
            model_bucket[p] = '0;
            model_rate[p]   = '0;
            model_thresh[p] = '0;
        end
        repeat (8) @(negedge packet_in);
        rst    = 1'b0;
        enable = '1;
        test_config();
        test_pass_through();
        test_fill();
        test_ports();
        test_drain();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/policer_pkg.sv
hw/policer_config.sv
hw/policer_head_detect.sv
hw/policer_bucket.sv
hw/policer_marker.sv
hw/policer_top.sv
verification/policer_tb.sv
